// ==== design/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
   input  femtoPkg::wordT    rs1,
   input  femtoPkg::wordT    rs2,
   input  femtoPkg::wordT    immI,
   input  femtoPkg::opcodeT  opcode,
   input  wire [2:0]         funct3,
   input  wire               altBit,
   output femtoPkg::wordT    aluOut,
   output femtoPkg::wordT    aluSum,
   output logic              takeBranch
);

   femtoPkg::wordT in2;
   logic [32:0]    minus;     // Shared subtract for SUB and compares
   logic           lt;
   logic           ltu;
   logic           eq;
   logic           isSub;
   femtoPkg::wordT shiftSrc;
   logic [32:0]    shiftFull;
   femtoPkg::wordT shiftRight;
   femtoPkg::wordT shiftLeft;

   function automatic femtoPkg::wordT bitRev(input femtoPkg::wordT v);
      femtoPkg::wordT r;
      for (int i = 0; i < femtoPkg::wordW; i++) begin
         r[i] = v[femtoPkg::wordW-1-i];
      end
      return r;
   endfunction

   // Register forms and branches compare rs2, the rest use immI
   assign in2 = (opcode == femtoPkg::opAluReg || opcode == femtoPkg::opBranch) ? rs2 : immI;

   assign aluSum = rs1 + in2; // Also the JALR target
   assign minus  = {1'b1, ~in2} + {1'b0, rs1} + 33'd1;
   assign ltu    = minus[32];
   assign lt     = (rs1[31] ^ in2[31]) ? rs1[31] : minus[32]; // Signs differ, rs1 sign decides
   assign eq     = (minus[31:0] == '0);
   assign isSub  = altBit && opcode == femtoPkg::opAluReg; // ADDI has bit 30 in its immediate

   // One arithmetic right shifter serves both directions
   assign shiftSrc   = (funct3 == 3'b001) ? bitRev(rs1) : rs1;
   assign shiftFull  = $signed({altBit & shiftSrc[31], shiftSrc}) >>> in2[4:0];
   assign shiftRight = shiftFull[31:0];
   assign shiftLeft  = bitRev(shiftRight);

   always_comb begin
      case (funct3)
         3'b000:  aluOut = isSub ? minus[31:0] : aluSum;
         3'b001:  aluOut = shiftLeft;           // SLL
         3'b010:  aluOut = {31'b0, lt};         // SLT
         3'b011:  aluOut = {31'b0, ltu};        // SLTU
         3'b100:  aluOut = rs1 ^ in2;
         3'b101:  aluOut = shiftRight;          // SRL or SRA
         3'b110:  aluOut = rs1 | in2;
         default: aluOut = rs1 & in2;
      endcase
   end

   // Branch predicate
   always_comb begin
      case (funct3)
         3'b000:  takeBranch = eq;   // BEQ
         3'b001:  takeBranch = !eq;  // BNE
         3'b100:  takeBranch = lt;   // BLT
         3'b101:  takeBranch = !lt;  // BGE
         3'b110:  takeBranch = ltu;  // BLTU
         3'b111:  takeBranch = !ltu; // BGEU
         default: takeBranch = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/busArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module busArbiter #(
   parameter int addrWidth = 24
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   fetchReq,
   input  wire [addrWidth-1:0]   pc,
   input  wire                   dataRead,
   input  wire [3:0]             dataMask,
   input  wire [addrWidth-1:0]   dataAddr,
   input  femtoPkg::wordT        dataWdata,
   input  wire                   memRbusy,
   input  wire                   memWbusy,
   output femtoPkg::wordT        memAddr,
   output femtoPkg::wordT        memWdata,
   output logic [3:0]            memWmask,
   output logic                  memRstrb,
   output logic                  busDone
);

   logic                 dataReq;
   logic                 ownerData;  // Set while the data side holds the bus
   logic [addrWidth-1:0] addrSel;

   assign dataReq = dataRead | (|dataMask);

   always_ff @(posedge clk) begin
      if (!reset) begin
         ownerData <= 1'b0;
      end else if (fetchReq) begin
         ownerData <= 1'b0;
      end else if (dataReq) begin
         ownerData <= 1'b1;
      end
   end

   // Requester wins on its request cycle, then the recorded owner
   assign addrSel = fetchReq  ? pc       :
                    dataReq   ? dataAddr :
                    ownerData ? dataAddr : pc;

   assign memAddr  = {{(femtoPkg::wordW-addrWidth){1'b0}}, addrSel};
   assign memWdata = dataWdata;
   assign memWmask = dataMask;
   assign memRstrb = fetchReq | dataRead;
   assign busDone  = !memRbusy && !memWbusy;

   // Fetch and data never ask in the same cycle
   assert property (@(posedge clk) disable iff (!reset) !(fetchReq && dataReq));

endmodule

`default_nettype wire

// ==== design/coreControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module coreControl #(
   parameter int          addrWidth = 24,
   parameter logic [31:0] resetAddr = 32'h0
) (
   input  wire                    clk,
   input  wire                    reset,
   input  femtoPkg::opcodeT       opcode,
   input  femtoPkg::wordT         immB,
   input  femtoPkg::wordT         immU,
   input  femtoPkg::wordT         immJ,
   input  femtoPkg::wordT         aluOut,
   input  femtoPkg::wordT         aluSum,
   input  wire                    takeBranch,
   input  femtoPkg::wordT         loadData,
   input  wire                    busDone,
   output logic [addrWidth-1:0]   pc,
   output logic                   fetchReq,
   output logic                   execStrobe,
   output logic                   instrLoad,
   output logic                   wbEnable,
   output femtoPkg::wordT         wbData
);

   localparam logic [femtoPkg::wordW-addrWidth-1:0] addrPad = '0;

   femtoPkg::stateT      state;
   logic                 isLoad;
   logic                 isStore;
   logic                 noWrite;   // Classes with no destination register
   femtoPkg::wordT       immSel;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm; // Shared by JAL, AUIPC and branches
   logic [addrWidth-1:0] pcNext;

   assign isLoad  = (opcode == femtoPkg::opLoad);
   assign isStore = (opcode == femtoPkg::opStore);
   assign noWrite = isStore || opcode == femtoPkg::opBranch || opcode == femtoPkg::opIllegal;

   assign immSel    = (opcode == femtoPkg::opJal)   ? immJ :
                      (opcode == femtoPkg::opAuipc) ? immU : immB;
   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = pc + immSel[addrWidth-1:0];

   always_comb begin
      if (opcode == femtoPkg::opJalr) begin
         pcNext = {aluSum[addrWidth-1:1], 1'b0};
      end else if (opcode == femtoPkg::opJal || (opcode == femtoPkg::opBranch && takeBranch)) begin
         pcNext = pcPlusImm;
      end else begin
         pcNext = pcPlus4;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= femtoPkg::stWaitMem; // Let a pending write drain first
         pc    <= resetAddr[addrWidth-1:0];
      end else begin
         case (state)
            femtoPkg::stFetch: state <= femtoPkg::stWaitInstr;
            femtoPkg::stWaitInstr: begin
               if (busDone) state <= femtoPkg::stExecute;
            end
            femtoPkg::stExecute: begin
               pc    <= pcNext;
               state <= (isLoad || isStore) ? femtoPkg::stWaitMem : femtoPkg::stFetch;
            end
            default: begin
               if (busDone) state <= femtoPkg::stFetch; // stWaitMem
            end
         endcase
      end
   end

   assign fetchReq   = (state == femtoPkg::stFetch);
   assign execStrobe = (state == femtoPkg::stExecute);
   assign instrLoad  = (state == femtoPkg::stWaitInstr) && busDone;

   // Loads write on their data cycle, the rest in execute
   assign wbEnable = (execStrobe && !isLoad && !noWrite) ||
                     (state == femtoPkg::stWaitMem && isLoad && busDone);

   always_comb begin
      case (opcode)
         femtoPkg::opLui:   wbData = immU;
         femtoPkg::opAuipc: wbData = {addrPad, pcPlusImm};
         femtoPkg::opJal,
         femtoPkg::opJalr:  wbData = {addrPad, pcPlus4}; // Link value
         femtoPkg::opLoad:  wbData = loadData;
         default:           wbData = aluOut;
      endcase
   end

   assert property (@(posedge clk) disable iff (!reset)
      state inside {femtoPkg::stFetch, femtoPkg::stWaitInstr,
                    femtoPkg::stExecute, femtoPkg::stWaitMem});

endmodule

`default_nettype wire

// ==== design/femtoCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module femtoCore #(
   parameter int          addrWidth = 24,
   parameter logic [31:0] resetAddr = 32'h0
) (
   input  wire             clk,
   input  wire             reset,
   output femtoPkg::wordT  memAddr,
   output femtoPkg::wordT  memWdata,
   output logic [3:0]      memWmask,
   output logic            memRstrb,
   input  femtoPkg::wordT  memRdata,
   input  wire             memRbusy,
   input  wire             memWbusy
);

   femtoPkg::opcodeT     opcode;
   logic [2:0]           funct3;
   logic                 altBit;
   femtoPkg::regIdT      rd;
   femtoPkg::wordT       immI;
   femtoPkg::wordT       immS;
   femtoPkg::wordT       immB;
   femtoPkg::wordT       immU;
   femtoPkg::wordT       immJ;
   femtoPkg::wordT       rs1;
   femtoPkg::wordT       rs2;
   femtoPkg::wordT       aluOut;
   femtoPkg::wordT       aluSum;
   logic                 takeBranch;
   femtoPkg::wordT       loadData;
   logic [addrWidth-1:0] dataAddr;
   logic                 dataRead;
   logic [3:0]           dataMask;
   femtoPkg::wordT       dataWdata;
   logic [addrWidth-1:0] pc;
   logic                 fetchReq;
   logic                 execStrobe;
   logic                 instrLoad;
   logic                 wbEnable;
   femtoPkg::wordT       wbData;
   logic                 busDone;

   instrDecoder decoder0 (
      .clk(clk), .reset(reset), .instrLoad(instrLoad), .memRdata(memRdata),
      .opcode(opcode), .funct3(funct3), .altBit(altBit), .rd(rd),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   regFile regs0 (
      .clk(clk), .instrLoad(instrLoad), .memRdata(memRdata),
      .wbEnable(wbEnable), .rd(rd), .wbData(wbData), .rs1(rs1), .rs2(rs2)
   );

   alu alu0 (
      .rs1(rs1), .rs2(rs2), .immI(immI), .opcode(opcode), .funct3(funct3),
      .altBit(altBit), .aluOut(aluOut), .aluSum(aluSum), .takeBranch(takeBranch)
   );

   loadStoreUnit #(.addrWidth(addrWidth)) lsu0 (
      .rs1(rs1), .rs2(rs2), .immI(immI), .immS(immS), .opcode(opcode),
      .funct3(funct3), .execStrobe(execStrobe), .memRdata(memRdata),
      .dataAddr(dataAddr), .dataRead(dataRead), .dataMask(dataMask),
      .dataWdata(dataWdata), .loadData(loadData)
   );

   busArbiter #(.addrWidth(addrWidth)) arb0 (
      .clk(clk), .reset(reset), .fetchReq(fetchReq), .pc(pc),
      .dataRead(dataRead), .dataMask(dataMask), .dataAddr(dataAddr),
      .dataWdata(dataWdata), .memRbusy(memRbusy), .memWbusy(memWbusy),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .memRstrb(memRstrb), .busDone(busDone)
   );

   coreControl #(.addrWidth(addrWidth), .resetAddr(resetAddr)) ctrl0 (
      .clk(clk), .reset(reset), .opcode(opcode), .immB(immB), .immU(immU),
      .immJ(immJ), .aluOut(aluOut), .aluSum(aluSum), .takeBranch(takeBranch),
      .loadData(loadData), .busDone(busDone), .pc(pc), .fetchReq(fetchReq),
      .execStrobe(execStrobe), .instrLoad(instrLoad), .wbEnable(wbEnable),
      .wbData(wbData)
   );

endmodule

`default_nettype wire

// ==== design/femtoPkg.sv ====
`default_nettype none

package femtoPkg;

   localparam int wordW = 32; // Data word width

   typedef logic [wordW-1:0] wordT; // One data word
   typedef logic [4:0]       regIdT; // Register index

   // Instruction classes, encoded as instruction bits 6:2
   typedef enum logic [4:0] {
      opLoad    = 5'b00000, // rd <- mem[rs1+immI]
      opAluImm  = 5'b00100, // rd <- rs1 op immI
      opAuipc   = 5'b00101, // rd <- PC + immU
      opStore   = 5'b01000, // mem[rs1+immS] <- rs2
      opAluReg  = 5'b01100, // rd <- rs1 op rs2
      opLui     = 5'b01101, // rd <- immU
      opBranch  = 5'b11000, // PC <- PC+immB if predicate holds
      opJalr    = 5'b11001, // rd <- PC+4, PC <- rs1+immI
      opJal     = 5'b11011, // rd <- PC+4, PC <- PC+immJ
      opIllegal = 5'b11111  // SYSTEM and anything unknown
   } opcodeT;

   // Control FSM states
   typedef enum logic [1:0] {
      stFetch     = 2'd0,
      stWaitInstr = 2'd1,
      stExecute   = 2'd2,
      stWaitMem   = 2'd3
   } stateT;

   // Access size, from funct3[1:0]
   typedef enum logic [1:0] {
      accByte = 2'b00,
      accHalf = 2'b01,
      accWord = 2'b10
   } accessT;

endpackage

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
   input  wire               clk,
   input  wire               reset,
   input  wire               instrLoad,
   input  femtoPkg::wordT    memRdata,
   output femtoPkg::opcodeT  opcode,
   output logic [2:0]        funct3,
   output logic              altBit,
   output femtoPkg::regIdT   rd,
   output femtoPkg::wordT    immI,
   output femtoPkg::wordT    immS,
   output femtoPkg::wordT    immB,
   output femtoPkg::wordT    immU,
   output femtoPkg::wordT    immJ
);

   localparam femtoPkg::wordT nopInstr = 32'h0000_0013; // ADDI x0,x0,0

   logic [31:2] instr; // Bits 1:0 are always 11 in RV32I

   always_ff @(posedge clk) begin
      if (!reset) begin
         instr <= nopInstr[31:2];
      end else if (instrLoad) begin
         instr <= memRdata[31:2];
      end
   end

   // Class decode from the opcode field
   always_comb begin
      case (instr[6:2])
         5'b00000: opcode = femtoPkg::opLoad;
         5'b00100: opcode = femtoPkg::opAluImm;
         5'b00101: opcode = femtoPkg::opAuipc;
         5'b01000: opcode = femtoPkg::opStore;
         5'b01100: opcode = femtoPkg::opAluReg;
         5'b01101: opcode = femtoPkg::opLui;
         5'b11000: opcode = femtoPkg::opBranch;
         5'b11001: opcode = femtoPkg::opJalr;
         5'b11011: opcode = femtoPkg::opJal;
         default:  opcode = femtoPkg::opIllegal; // SYSTEM lands here too
      endcase
   end

   assign funct3 = instr[14:12];
   assign altBit = instr[30];      // SUB and SRA select
   assign rd     = instr[11:7];

   // Sign-extended immediates, one per format
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // A freshly fetched word must decode to a known class
   assert property (@(posedge clk) disable iff (!reset)
      instrLoad |=> opcode != femtoPkg::opIllegal);

endmodule

`default_nettype wire

// ==== design/loadStoreUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module loadStoreUnit #(
   parameter int addrWidth = 24
) (
   input  femtoPkg::wordT         rs1,
   input  femtoPkg::wordT         rs2,
   input  femtoPkg::wordT         immI,
   input  femtoPkg::wordT         immS,
   input  femtoPkg::opcodeT       opcode,
   input  wire [2:0]              funct3,
   input  wire                    execStrobe,
   input  femtoPkg::wordT         memRdata,
   output logic [addrWidth-1:0]   dataAddr,
   output logic                   dataRead,
   output logic [3:0]             dataMask,
   output femtoPkg::wordT         dataWdata,
   output femtoPkg::wordT         loadData
);

   logic             isLoad;
   logic             isStore;
   femtoPkg::wordT   offset;
   femtoPkg::accessT accSize;
   logic [3:0]       storeMask;
   logic [15:0]      loadHalf;
   logic [7:0]       loadByte;
   logic             loadSign;

   assign isLoad  = (opcode == femtoPkg::opLoad);
   assign isStore = (opcode == femtoPkg::opStore);
   assign accSize = femtoPkg::accessT'(funct3[1:0]);

   assign offset   = isStore ? immS : immI;
   assign dataAddr = rs1[addrWidth-1:0] + offset[addrWidth-1:0];

   // Store data, low bytes replicated into the addressed lanes
   assign dataWdata[7:0]   = rs2[7:0];
   assign dataWdata[15:8]  = dataAddr[0] ? rs2[7:0] : rs2[15:8];
   assign dataWdata[23:16] = dataAddr[1] ? rs2[7:0] : rs2[23:16];
   assign dataWdata[31:24] = dataAddr[0] ? rs2[7:0] :
                             dataAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      case (accSize)
         femtoPkg::accByte: storeMask = 4'b0001 << dataAddr[1:0];
         femtoPkg::accHalf: storeMask = dataAddr[1] ? 4'b1100 : 4'b0011;
         default:           storeMask = 4'b1111;
      endcase
   end

   assign dataRead = execStrobe & isLoad;             // One-cycle read strobe
   assign dataMask = {4{execStrobe & isStore}} & storeMask;

   // Load lane extraction
   assign loadHalf = dataAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = dataAddr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = !funct3[2] &                     // LBU and LHU zero-extend
                     (accSize == femtoPkg::accByte ? loadByte[7] : loadHalf[15]);

   always_comb begin
      case (accSize)
         femtoPkg::accByte: loadData = {{24{loadSign}}, loadByte};
         femtoPkg::accHalf: loadData = {{16{loadSign}}, loadHalf};
         default:           loadData = memRdata;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
   input  wire              clk,
   input  wire              instrLoad,
   input  femtoPkg::wordT   memRdata,
   input  wire              wbEnable,
   input  femtoPkg::regIdT  rd,
   input  femtoPkg::wordT   wbData,
   output femtoPkg::wordT   rs1,
   output femtoPkg::wordT   rs2
);

   femtoPkg::wordT regs [0:31];

   femtoPkg::regIdT rs1Id;
   femtoPkg::regIdT rs2Id;

   assign rs1Id = memRdata[19:15]; // Source fields straight off the bus
   assign rs2Id = memRdata[24:20];

   always_ff @(posedge clk) begin
      if (wbEnable && rd != 5'd0) begin
         regs[rd] <= wbData; // x0 is never written
      end
   end

   // Operand latches, x0 reads as zero
   always_ff @(posedge clk) begin
      if (instrLoad) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

// ==== flist.f ====
design/femtoPkg.sv
design/instrDecoder.sv
design/regFile.sv
design/alu.sv
design/loadStoreUnit.sv
design/busArbiter.sv
design/coreControl.sv
design/femtoCore.sv
tb/tbClock.sv
tb/coreTb.sv

// ==== tb/coreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module coreTb;

   localparam int kAlu   = 0; // LW, LW, test word, SW x3
   localparam int kBr    = 1; // Branch over ADDI x3
   localparam int kLd    = 2; // Load from operand a's word
   localparam int kSt    = 3; // Sub-word store of x2 into the slot
   localparam int kLui   = 4;
   localparam int kAuipc = 5;
   localparam int kJal   = 6;
   localparam int kJalr  = 7;
   localparam int kZero  = 8; // Write x0 then store it
   localparam int dataBase = 32'h400;
   localparam int slotBase = 32'h600;

   logic           clk;
   logic           reset;
   femtoPkg::wordT memAddr;
   femtoPkg::wordT memWdata;
   logic [3:0]     memWmask;
   logic           memRstrb;
   femtoPkg::wordT memRdata;
   logic           memRbusy;
   logic           memWbusy;

   femtoPkg::wordT mem [0:1023]; // 4 KB
   int             rowKind [0:63];
   femtoPkg::wordT rowInstr [0:63];
   femtoPkg::wordT rowA [0:63];
   femtoPkg::wordT rowB [0:63];
   femtoPkg::wordT rowExp [0:63];
   logic [3:0]     rowMask [0:63];
   femtoPkg::wordT expWord [0:63];
   femtoPkg::wordT expAddr [0:63];
   int             numRows = 0;
   int             storeIdx = 0;
   int             errors = 0;
   int             cycles = 0;
   int             pcAddr = 0;
   int             rdPend = 0;
   int             wrPend = 0;
   logic           lastRstrb = 1'b0; // Strobe seen on the previous falling edge
   logic [31:0]    lfsr = 32'h4308;

   tbClock clkGen0 (.clk(clk), .reset(reset));

   femtoCore #(.addrWidth(24), .resetAddr(32'h0)) dut0 (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRstrb(memRstrb), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   // RV32I encoders
   function automatic femtoPkg::wordT iType(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic femtoPkg::wordT rType(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011}; // x3 <- x1 op x2
   endfunction

   function automatic femtoPkg::wordT sType(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic femtoPkg::wordT bType(input logic [12:0] imm, input logic [2:0] f3);
      return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic femtoPkg::wordT jType(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   function automatic femtoPkg::wordT laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // Galois LFSR stepped once per bit
   task automatic nextBit(output logic b);
      b = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
   endtask

   task automatic drawBusy(output int n);
      logic b0;
      logic b1;
      nextBit(b0);
      nextBit(b1);
      n = {b1, b0}; // 0 to 3 stall cycles
   endtask

   task automatic addRow(input int kind, input femtoPkg::wordT instr, input femtoPkg::wordT a,
                         input femtoPkg::wordT b, input femtoPkg::wordT exp,
                         input logic [3:0] mask);
      rowKind[numRows]  = kind;
      rowInstr[numRows] = instr;
      rowA[numRows]     = a;
      rowB[numRows]     = b;
      rowExp[numRows]   = exp;
      rowMask[numRows]  = mask;
      numRows++;
   endtask

   task automatic emit(input femtoPkg::wordT w);
      mem[pcAddr >> 2] = w;
      pcAddr += 4;
   endtask

   task automatic checkWord(input string name, input femtoPkg::wordT got,
                            input femtoPkg::wordT exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkMask(input string name, input logic [3:0] got, input logic [3:0] exp);
      if (got !== exp) begin
         errors++;
         $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Memory model and store monitor run on the falling edge
   always @(negedge clk) begin
      if (reset && memWmask != 4'b0) begin
         if (storeIdx >= numRows) begin
            errors++;
            $display("Unexpected store at t=%0t to address %h", $time, memAddr);
         end else begin
            checkMask($sformatf("row %0d memWmask", storeIdx), memWmask, rowMask[storeIdx]);
            checkWord($sformatf("row %0d memAddr", storeIdx), memAddr & ~32'h3,
                      expAddr[storeIdx]);
            checkWord($sformatf("row %0d memWdata", storeIdx),
                      memWdata & laneBits(rowMask[storeIdx]), expWord[storeIdx]);
         end
         for (int i = 0; i < 4; i++) begin
            if (memWmask[i]) mem[memAddr[11:2]][8*i +: 8] = memWdata[8*i +: 8];
         end
         storeIdx++;
         drawBusy(wrPend);
         memWbusy <= (wrPend != 0);
      end else begin
         memWbusy <= (wrPend != 0);
         if (wrPend > 0) wrPend--;
      end
      // A read request is a single-cycle pulse
      if (reset && memRstrb !== 1'b0 && (memRstrb !== 1'b1 || lastRstrb)) begin
         errors++;
         $display("Read strobe at t=%0t is unknown or longer than one cycle", $time);
      end
      lastRstrb = (memRstrb === 1'b1);
      if (memRstrb === 1'b1) begin
         memRdata <= mem[memAddr[11:2]]; // Registered read
         drawBusy(rdPend);
         memRbusy <= (rdPend != 0);
      end else begin
         memRbusy <= (rdPend != 0);
         if (rdPend > 0) rdPend--;
      end
   end

   initial begin
      int addrA;
      int slot;
      int off;
      int limit;
      femtoPkg::wordT exp;
      femtoPkg::wordT swX3;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      for (int i = 0; i < 1024; i++) begin
         mem[i] = {~i[15:0], i[15:0]}; // Distinct pattern in every word
      end

      addRow(kAlu, rType(7'h00, 3'd0), 32'h7FFF_FFFF, 32'h1, 32'h8000_0000, 4'hF); // ADD
      addRow(kAlu, rType(7'h20, 3'd0), 32'h5, 32'h7, 32'hFFFF_FFFE, 4'hF);         // SUB
      addRow(kAlu, rType(7'h00, 3'd2), 32'hFFFF_FFF0, 32'h3, 32'h1, 4'hF);         // SLT
      addRow(kAlu, rType(7'h00, 3'd3), 32'hFFFF_FFF0, 32'h3, 32'h0, 4'hF);         // SLTU
      addRow(kAlu, rType(7'h00, 3'd4), 32'hF0F0_1234, 32'h0FF0_FF00, 32'hFF00_ED34, 4'hF);
      addRow(kAlu, rType(7'h00, 3'd6), 32'hF000_000F, 32'h0000_0F00, 32'hF000_0F0F, 4'hF);
      addRow(kAlu, rType(7'h00, 3'd7), 32'hFF00_FF00, 32'h0F0F_0F0F, 32'h0F00_0F00, 4'hF);
      addRow(kAlu, rType(7'h00, 3'd1), 32'h8000_0001, 32'h24, 32'h10, 4'hF);      // SLL by 4
      addRow(kAlu, rType(7'h00, 3'd5), 32'h8000_0000, 32'd31, 32'h1, 4'hF);       // SRL
      addRow(kAlu, rType(7'h20, 3'd5), 32'h8000_0000, 32'd4, 32'hF800_0000, 4'hF); // SRA
      addRow(kAlu, iType(12'hFFD, 5'd1, 3'd0, 5'd3, 7'b0010011), 32'd10, 32'h0, 32'd7, 4'hF);
      addRow(kAlu, iType(12'h408, 5'd1, 3'd5, 5'd3, 7'b0010011), 32'h8765_4321, 32'h0,
             32'hFF87_6543, 4'hF);                                                // SRAI 8
      // Branch rows store 0 when taken and 1 when not
      addRow(kBr, bType(13'd8, 3'd0), 32'h5, 32'h5, 32'h0, 4'hF);                 // BEQ
      addRow(kBr, bType(13'd8, 3'd1), 32'h5, 32'h5, 32'h1, 4'hF);                 // BNE
      addRow(kBr, bType(13'd8, 3'd4), 32'hFFFF_FFFF, 32'h1, 32'h0, 4'hF);         // BLT
      addRow(kBr, bType(13'd8, 3'd5), 32'hFFFF_FFFF, 32'h1, 32'h1, 4'hF);         // BGE
      addRow(kBr, bType(13'd8, 3'd6), 32'hFFFF_FFFF, 32'h1, 32'h1, 4'hF);         // BLTU
      addRow(kBr, bType(13'd8, 3'd7), 32'hFFFF_FFFF, 32'h1, 32'h0, 4'hF);         // BGEU
      // Load immediates hold the lane offset
      addRow(kLd, iType(12'd0, 5'd0, 3'd0, 5'd3, 7'b0000011), 32'h80F2_7F81, 32'h0,
             32'hFFFF_FF81, 4'hF);                                                // LB
      addRow(kLd, iType(12'd3, 5'd0, 3'd4, 5'd3, 7'b0000011), 32'h80F2_7F81, 32'h0,
             32'h0000_0080, 4'hF);                                                // LBU
      addRow(kLd, iType(12'd1, 5'd0, 3'd0, 5'd3, 7'b0000011), 32'h80F2_7F81, 32'h0,
             32'h0000_007F, 4'hF);
      addRow(kLd, iType(12'd2, 5'd0, 3'd1, 5'd3, 7'b0000011), 32'h80F2_7F81, 32'h0,
             32'hFFFF_80F2, 4'hF);                                                // LH
      addRow(kLd, iType(12'd2, 5'd0, 3'd5, 5'd3, 7'b0000011), 32'h80F2_7F81, 32'h0,
             32'h0000_80F2, 4'hF);                                                // LHU
      addRow(kLd, iType(12'd0, 5'd0, 3'd1, 5'd3, 7'b0000011), 32'h80F2_7F81, 32'h0,
             32'h0000_7F81, 4'hF);
      // Sub-word stores of x2 expect the data in the addressed lanes
      addRow(kSt, sType(12'd0, 5'd2, 5'd0, 3'd0), 32'h0, 32'hA1B2_C3D4, 32'h0000_00D4, 4'b0001);
      addRow(kSt, sType(12'd1, 5'd2, 5'd0, 3'd0), 32'h0, 32'hA1B2_C3D4, 32'h0000_D400, 4'b0010);
      addRow(kSt, sType(12'd3, 5'd2, 5'd0, 3'd0), 32'h0, 32'hA1B2_C3D4, 32'hD400_0000, 4'b1000);
      addRow(kSt, sType(12'd0, 5'd2, 5'd0, 3'd1), 32'h0, 32'hA1B2_C3D4, 32'h0000_C3D4, 4'b0011);
      addRow(kSt, sType(12'd2, 5'd2, 5'd0, 3'd1), 32'h0, 32'hA1B2_C3D4, 32'hC3D4_0000, 4'b1100);
      addRow(kLui, {20'h12345, 5'd3, 7'b0110111}, 32'h0, 32'h0, 32'h1234_5000, 4'hF);
      addRow(kAuipc, {20'h00001, 5'd3, 7'b0010111}, 32'h0, 32'h0, 32'h0000_1000, 4'hF);
      addRow(kJal, jType(21'd8, 5'd3), 32'h0, 32'h0, 32'h0, 4'hF);
      addRow(kJalr, 32'h0, 32'h0, 32'h0, 32'h0, 4'hF);                          // Built below
      addRow(kZero, iType(12'd5, 5'd1, 3'd0, 5'd0, 7'b0010011), 32'h55, 32'h0, 32'h0, 4'hF);

      for (int i = 0; i < numRows; i++) begin
         addrA = dataBase + 8 * i;
         slot  = slotBase + 4 * i;
         exp   = rowExp[i];
         swX3  = sType(slot, 5'd3, 5'd0, 3'd2);
         mem[addrA >> 2]       = rowA[i];
         mem[(addrA + 4) >> 2] = rowB[i];
         emit(iType(addrA, 5'd0, 3'd2, 5'd1, 7'b0000011));     // LW x1
         emit(iType(addrA + 4, 5'd0, 3'd2, 5'd2, 7'b0000011)); // LW x2
         case (rowKind[i])
            kBr: begin
               emit(iType(12'd0, 5'd0, 3'd0, 5'd3, 7'b0010011)); // x3 = 0
               emit(rowInstr[i]);
               emit(iType(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011)); // Skipped when taken
               emit(swX3);
            end
            kLd: begin
               emit(rowInstr[i] + (addrA << 20)); // Offset plus operand address
               emit(swX3);
            end
            kSt: begin
               off = {rowInstr[i][31:25], rowInstr[i][11:7]};
               emit(sType(slot + off, rowInstr[i][24:20], rowInstr[i][19:15],
                          rowInstr[i][14:12]));
            end
            kAuipc: begin
               exp = pcAddr + rowExp[i];
               emit(rowInstr[i]);
               emit(swX3);
            end
            kJal: begin
               exp = pcAddr + 4; // Link points at the skipped ADDI
               emit(rowInstr[i]);
               emit(iType(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011)); // Clobbers x3 if not skipped
               emit(swX3);
            end
            kJalr: begin
               exp = pcAddr + 4;
               // Odd target that lands on the SW once bit 0 is cleared
               emit(iType(pcAddr + 9, 5'd0, 3'd0, 5'd3, 7'b1100111));
               emit(iType(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011)); // Clobbers x3 if not skipped
               emit(swX3);
            end
            kZero: begin
               emit(rowInstr[i]);
               emit(sType(slot, 5'd0, 5'd0, 3'd2)); // SW x0
            end
            default: begin
               emit(rowInstr[i]);
               emit(swX3);
            end
         endcase
         expWord[i] = exp;
         expAddr[i] = slot;
      end
      emit(jType(21'd0, 5'd0)); // Park the core

      limit = numRows * 4 * 8 + 200;
      wait (reset === 1'b1);
      while (storeIdx < numRows && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (storeIdx < numRows) begin
         errors++;
         $display("Timeout after %0d cycles, only %0d of %0d stores arrived",
                  cycles, storeIdx, numRows);
      end
      repeat (4) @(posedge clk);
      $display("Rows %0d, stores %0d, cycles %0d, errors %0d", numRows, storeIdx, cycles, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
   parameter int periodNs    = 8,
   parameter int resetCycles = 5
) (
   output logic clk,
   output logic reset
);

   initial clk = 1'b0;
   always #(periodNs / 2) clk = ~clk; // 8 ns period

   // Active low reset, released on a falling edge
   initial begin
      reset = 1'b0;
      repeat (resetCycles) @(negedge clk);
      reset = 1'b1;
   end

endmodule

`default_nettype wire
